/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = dcache_tb
FILELIST = files.f
OUTDIR   = obj_dir
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OUTDIR)/V$(TOP)

$(OUTDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OUTDIR)

# the log decides the result, whatever the simulator returns
run: compile
	./$(OUTDIR)/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OUTDIR) $(LOG)

/* files.f */
logic/cache_pkg.sv
logic/tag_array.sv
logic/data_array.sv
logic/way_lfsr.sv
logic/store_lane.sv
logic/cache_ctrl.sv
logic/dcache_top.sv
test/main_mem_model.sv
test/dcache_tb.sv

/* logic/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                               clk,
    input  logic                               init,
    input  logic                               req_valid,
    input  cache_pkg::cpu_req_t                req,
    input  logic                               hit,
    input  logic                               hit_way,
    input  logic [cache_pkg::N_WAYS-1:0]       ways_valid,
    input  logic                               rand_way,
    input  logic                               mem_req_ready,
    input  logic                               mem_resp_valid,
    output cache_pkg::cpu_req_t                lreq,
    output logic                               arr_en,
    output logic [cache_pkg::N_INDEX_BITS-1:0] arr_index,
    output logic                               tag_we,
    output logic                               data_we,
    output logic                               fill,
    output logic                               way_sel,
    output logic                               step,
    output logic                               resp_valid,
    output logic                               mem_req_valid,
    output cache_pkg::req_type_e               mem_req_type
);
    cache_pkg::ctrl_state_e state;
    cache_pkg::ctrl_state_e next_state;
    logic                   req_sent;   // write-through already accepted
    logic                   refill_way;

    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            state    <= cache_pkg::IDLE;
            req_sent <= 1'b0;
        end else begin
            state <= next_state;
            if (mem_resp_valid) begin
                req_sent <= 1'b0;
            end else if (mem_req_valid && mem_req_ready) begin
                req_sent <= 1'b1;
            end
        end
    end

    // request held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == cache_pkg::IDLE && req_valid) begin
            lreq <= req;
        end
    end

    always_comb begin
        next_state    = state;
        resp_valid    = 1'b0;
        mem_req_valid = 1'b0;
        fill          = 1'b0;
        data_we       = 1'b0;
        unique case (state)
            cache_pkg::IDLE: begin
                if (req_valid) begin
                    next_state = cache_pkg::LOOKUP;
                end
            end
            cache_pkg::LOOKUP: begin
                if (!hit) begin
                    next_state = cache_pkg::MEM_REQ;
                end else if (lreq.rtype == cache_pkg::WRITE) begin
                    resp_valid    = 1'b1;
                    data_we       = 1'b1;   // merge into the hit way
                    mem_req_valid = 1'b1;   // and send the block through
                    next_state    = cache_pkg::WT_WAIT;
                end else begin
                    resp_valid = 1'b1;
                    next_state = cache_pkg::IDLE;
                end
            end
            cache_pkg::MEM_REQ: begin
                mem_req_valid = 1'b1;
                if (mem_req_ready) begin
                    next_state = cache_pkg::MEM_WAIT;
                end
            end
            cache_pkg::MEM_WAIT: begin
                if (mem_resp_valid) begin
                    fill       = 1'b1;
                    data_we    = 1'b1;
                    next_state = cache_pkg::REFILL;
                end
            end
            cache_pkg::REFILL: begin
                next_state = cache_pkg::LOOKUP;  // re-read the filled set
            end
            cache_pkg::WT_WAIT: begin
                mem_req_valid = !req_sent;
                if (mem_resp_valid) begin
                    next_state = cache_pkg::IDLE;
                end
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    // first invalid way, random when the set is full
    assign refill_way = !ways_valid[0] ? 1'b0 :
                        !ways_valid[1] ? 1'b1 : rand_way;

    assign tag_we       = fill;
    assign step         = fill;
    assign way_sel      = fill ? refill_way : hit_way;
    assign arr_en       = (state == cache_pkg::IDLE && req_valid) || data_we ||
                          (state == cache_pkg::REFILL);
    assign arr_index    = (state == cache_pkg::IDLE) ? req.addr.index : lreq.addr.index;
    assign mem_req_type = (state == cache_pkg::MEM_REQ) ? cache_pkg::READ : cache_pkg::WRITE;

    assert property (@(posedge clk) disable iff (init)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req_type)))
        else $error("cache_ctrl: mem_req dropped or changed, type %h", mem_req_type);

    // one response per request
    assert property (@(posedge clk) disable iff (init) resp_valid |=> !resp_valid)
        else $error("cache_ctrl: resp_valid high twice, state %h", state);

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

    // address and data sizes
    localparam int ADDR_WIDTH       = 16;  // byte address
    localparam int WORD_WIDTH       = 32;
    localparam int BLOCK_WIDTH      = 64;
    localparam int BLOCK_BYTES      = BLOCK_WIDTH / 8;

    // cache geometry
    localparam int N_OFFSET_BITS    = 3;
    localparam int N_SETS           = 16;
    localparam int N_INDEX_BITS     = 4;
    localparam int N_TAG_BITS       = ADDR_WIDTH - N_INDEX_BITS - N_OFFSET_BITS;
    localparam int N_WAYS           = 2;
    localparam int BLOCK_ADDR_WIDTH = N_TAG_BITS + N_INDEX_BITS;

    localparam logic [7:0] LFSR_SEED = 8'hb5;
    localparam logic [7:0] LFSR_TAPS = 8'hb8;  // x^8 + x^6 + x^5 + x^4 + 1

    typedef enum logic {READ, WRITE} req_type_e;

    typedef enum logic [1:0] {BYTE, HALF, WORD} req_width_e;

    typedef enum logic [2:0] {IDLE, LOOKUP, MEM_REQ, MEM_WAIT, REFILL, WT_WAIT} ctrl_state_e;

    typedef struct packed {
        logic [N_TAG_BITS-1:0]    tag;
        logic [N_INDEX_BITS-1:0]  index;
        logic [N_OFFSET_BITS-1:0] offset;
    } addr_fields_t;

    typedef struct packed {
        req_type_e               rtype;
        req_width_e              width;
        addr_fields_t            addr;
        logic [WORD_WIDTH-1:0]   wr_data;  // stores only
    } cpu_req_t;

    typedef struct packed {
        req_type_e                   rtype;
        logic [BLOCK_ADDR_WIDTH-1:0] block_addr;  // tag and index
        logic [BLOCK_WIDTH-1:0]      data;        // write-through block
    } mem_req_t;

    typedef struct packed {
        logic                  valid;
        logic [N_TAG_BITS-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        tag_entry_t [N_WAYS-1:0] way;
    } tag_set_t;

    typedef struct packed {
        logic [N_WAYS-1:0][BLOCK_WIDTH-1:0] blk;
    } data_set_t;

endpackage

/* logic/data_array.sv */
`timescale 1ns/1ps

module data_array (
    input  logic                               clk,
    input  logic                               en,
    input  logic [cache_pkg::N_INDEX_BITS-1:0] index,
    input  logic                               we,
    input  logic                               way_sel,
    input  logic                               fill,
    input  logic [cache_pkg::BLOCK_WIDTH-1:0]  fill_block,
    input  logic [cache_pkg::BLOCK_WIDTH-1:0]  wr_block,
    input  logic [cache_pkg::BLOCK_BYTES-1:0]  byte_mask,
    output cache_pkg::data_set_t               rd_set
);
    logic [cache_pkg::BLOCK_WIDTH-1:0] mem [cache_pkg::N_SETS][cache_pkg::N_WAYS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (we && fill) begin
                mem[index][way_sel] <= fill_block;  // refill replaces the block
            end else if (we) begin
                for (int b = 0; b < cache_pkg::BLOCK_BYTES; b++) begin
                    if (byte_mask[b]) begin
                        mem[index][way_sel][8*b +: 8] <= wr_block[8*b +: 8];
                    end
                end
            end
            // read returns the set as it was before this edge
            for (int w = 0; w < cache_pkg::N_WAYS; w++) begin
                rd_set.blk[w] <= mem[index][w];
            end
        end
    end

    // refills and store merges are separate writes
    assert property (@(posedge clk) (en && we && fill) |-> (byte_mask == '0))
        else $error("data_array: fill with byte_mask %h", byte_mask);

endmodule

/* logic/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                              clk,
    input  logic                              init,
    input  logic                              req_valid,
    input  cache_pkg::cpu_req_t               req,
    output logic                              resp_valid,
    output logic [cache_pkg::WORD_WIDTH-1:0]  resp_data,
    output logic                              mem_req_valid,
    output cache_pkg::mem_req_t               mem_req,
    input  logic                              mem_req_ready,
    input  logic                              mem_resp_valid,
    input  logic [cache_pkg::BLOCK_WIDTH-1:0] mem_resp_data
);
    cache_pkg::cpu_req_t               lreq;
    cache_pkg::req_type_e              mem_req_type;
    cache_pkg::data_set_t              rd_set;
    logic                              arr_en;
    logic [cache_pkg::N_INDEX_BITS-1:0] arr_index;
    logic                              tag_we;
    logic                              data_we;
    logic                              fill;
    logic                              way_sel;
    logic                              step;
    logic                              hit;
    logic                              hit_way;
    logic [cache_pkg::N_WAYS-1:0]      ways_valid;
    logic                              rand_way;
    logic [cache_pkg::BLOCK_BYTES-1:0] byte_mask;
    logic [cache_pkg::BLOCK_BYTES-1:0] store_mask;
    logic [cache_pkg::BLOCK_WIDTH-1:0] wr_block;

    assign store_mask         = fill ? '0 : byte_mask;  // a refill writes the whole block
    assign mem_req.rtype      = mem_req_type;
    assign mem_req.block_addr = {lreq.addr.tag, lreq.addr.index};
    assign mem_req.data       = wr_block;               // merged block for write-through

    cache_ctrl ctrl_i (
        .clk, .init, .req_valid, .req, .hit, .hit_way, .ways_valid, .rand_way,
        .mem_req_ready, .mem_resp_valid, .lreq, .arr_en, .arr_index, .tag_we,
        .data_we, .fill, .way_sel, .step, .resp_valid, .mem_req_valid, .mem_req_type
    );

    tag_array tags_i (
        .clk, .init, .en(arr_en), .index(arr_index), .we(tag_we), .way_sel,
        .tag_in(lreq.addr.tag), .cmp_tag(lreq.addr.tag), .hit, .hit_way, .ways_valid
    );

    data_array data_i (
        .clk, .en(arr_en), .index(arr_index), .we(data_we), .way_sel, .fill,
        .fill_block(mem_resp_data), .wr_block, .byte_mask(store_mask), .rd_set
    );

    way_lfsr lfsr_i (
        .clk, .init, .step, .rand_way
    );

    store_lane lane_i (
        .lreq, .rd_set, .hit_way, .byte_mask, .wr_block, .resp_data
    );

endmodule

/* logic/store_lane.sv */
`timescale 1ns/1ps

module store_lane (
    input  cache_pkg::cpu_req_t               lreq,
    input  cache_pkg::data_set_t              rd_set,
    input  logic                              hit_way,
    output logic [cache_pkg::BLOCK_BYTES-1:0] byte_mask,
    output logic [cache_pkg::BLOCK_WIDTH-1:0] wr_block,
    output logic [cache_pkg::WORD_WIDTH-1:0]  resp_data
);
    logic [cache_pkg::N_OFFSET_BITS-1:0] offset;
    logic [cache_pkg::BLOCK_WIDTH-1:0]   blk;
    logic [cache_pkg::BLOCK_WIDTH-1:0]   st_data;
    logic [cache_pkg::BLOCK_BYTES-1:0]   base_mask;

    assign offset = lreq.addr.offset;
    assign blk    = rd_set.blk[hit_way];

    always_comb begin
        unique case (lreq.width)
            cache_pkg::BYTE: begin
                base_mask = 8'b0000_0001;
                st_data   = {8{lreq.wr_data[7:0]}};
            end
            cache_pkg::HALF: begin
                base_mask = 8'b0000_0011;
                st_data   = {4{lreq.wr_data[15:0]}};
            end
            default: begin
                base_mask = 8'b0000_1111;
                st_data   = {2{lreq.wr_data}};
            end
        endcase
    end

    // loads leave the block untouched
    assign byte_mask = (lreq.rtype == cache_pkg::WRITE) ? (base_mask << offset) : '0;

    always_comb begin
        for (int b = 0; b < cache_pkg::BLOCK_BYTES; b++) begin
            wr_block[8*b +: 8] = byte_mask[b] ? st_data[8*b +: 8] : blk[8*b +: 8];
        end
    end

    assign resp_data = offset[2] ? blk[63:32] : blk[31:0];  // upper or lower word

    always_comb begin
        if (lreq.rtype == cache_pkg::WRITE && lreq.width == cache_pkg::HALF) begin
            assert (!offset[0]) else $error("store_lane: odd half offset %h", offset);
        end
        if (lreq.rtype == cache_pkg::WRITE && lreq.width == cache_pkg::WORD) begin
            assert (offset[1:0] == 2'b00) else $error("store_lane: word offset %h", offset);
        end
    end

endmodule

/* logic/tag_array.sv */
`timescale 1ns/1ps

module tag_array (
    input  logic                               clk,
    input  logic                               init,
    input  logic                               en,
    input  logic [cache_pkg::N_INDEX_BITS-1:0] index,
    input  logic                               we,
    input  logic                               way_sel,
    input  logic [cache_pkg::N_TAG_BITS-1:0]   tag_in,
    input  logic [cache_pkg::N_TAG_BITS-1:0]   cmp_tag,
    output logic                               hit,
    output logic                               hit_way,
    output logic [cache_pkg::N_WAYS-1:0]       ways_valid
);
    logic [cache_pkg::N_WAYS-1:0]     valid [cache_pkg::N_SETS];
    logic [cache_pkg::N_TAG_BITS-1:0] tags  [cache_pkg::N_SETS][cache_pkg::N_WAYS];
    logic [cache_pkg::N_WAYS-1:0]     rd_valid;
    logic [cache_pkg::N_TAG_BITS-1:0] rd_tag [cache_pkg::N_WAYS];
    cache_pkg::tag_set_t              rd_set;
    logic [cache_pkg::N_WAYS-1:0]     match;

    // valid bits, cleared on init
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            for (int s = 0; s < cache_pkg::N_SETS; s++) begin
                valid[s] <= '0;
            end
            rd_valid <= '0;
        end else if (en) begin
            if (we) begin
                valid[index][way_sel] <= 1'b1;
            end
            rd_valid <= valid[index];  // old contents on a write
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                tags[index][way_sel] <= tag_in;
            end
            for (int w = 0; w < cache_pkg::N_WAYS; w++) begin
                rd_tag[w] <= tags[index][w];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < cache_pkg::N_WAYS; w++) begin
            rd_set.way[w].valid = rd_valid[w];
            rd_set.way[w].tag   = rd_tag[w];
            match[w] = rd_set.way[w].valid && (rd_set.way[w].tag == cmp_tag);
        end
    end

    assign hit        = |match;
    assign hit_way    = match[1];
    assign ways_valid = rd_valid;

    // a tag is only filled after it missed in both ways
    assert property (@(posedge clk) disable iff (init) !(match[0] && match[1]))
        else $error("tag_array: both ways match tag %h", cmp_tag);

endmodule

/* logic/way_lfsr.sv */
`timescale 1ns/1ps

module way_lfsr (
    input  logic clk,
    input  logic init,
    input  logic step,
    output logic rand_way
);
    logic [7:0] state;

    // galois form, shifting right
    always_ff @(posedge clk or posedge init) begin
        if (init) begin
            state <= cache_pkg::LFSR_SEED;
        end else if (step) begin
            if (state[0]) begin
                state <= {1'b0, state[7:1]} ^ cache_pkg::LFSR_TAPS;
            end else begin
                state <= {1'b0, state[7:1]};
            end
        end
    end

    assign rand_way = state[0];  // way picked when both are valid

endmodule

/* test/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;
    logic                              clk;
    logic                              init;
    logic                              req_valid;
    cache_pkg::cpu_req_t               req;
    logic                              resp_valid;
    logic [cache_pkg::WORD_WIDTH-1:0]  resp_data;
    logic                              mem_req_valid;
    cache_pkg::mem_req_t               mem_req;
    logic                              mem_req_ready;
    logic                              mem_resp_valid;
    logic [cache_pkg::BLOCK_WIDTH-1:0] mem_resp_data;
    logic                              stall;
    logic                              stall_on;
    logic [7:0]  shadow [65536];   // byte image of main memory
    logic [31:0] rng;
    logic [31:0] stall_rng;
    logic [31:0] exp_word;
    logic [63:0] exp_block;
    logic        req_fresh;        // first cycle of a request
    logic        expect_hit;
    logic        expect_miss;
    logic        check_refetch;
    int resp_count = 0;
    int total_reads = 0;
    int total_writes = 0;
    int reads_at_issue = 0;
    int reads_mark = 0;
    int errors = 0;
    int test_mark = 0;
    int tests_failed = 0;
    int cycles = 0;
    int cycle_limit = 2 * 16 + 40 * 51 + 2000;  // two resets, 51 requests, margin

    dcache_top dcache_top_i (.*);

    main_mem_model mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [7:0] start_byte(input logic [15:0] a);
        return (a[7:0] * 8'h3b + 8'h11) ^ a[15:8];
    endfunction

    function automatic logic [31:0] shadow_word(input logic [15:0] addr);
        logic [31:0] w;
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = shadow[{addr[15:2], b[1:0]}];
        end
        return w;
    endfunction

    function automatic logic [63:0] shadow_block(input logic [15:0] addr);
        logic [63:0] blk;
        for (int b = 0; b < 8; b++) begin
            blk[8*b +: 8] = shadow[{addr[15:3], b[2:0]}];
        end
        return blk;
    endfunction

    function automatic cache_pkg::req_width_e pick_width(input logic [1:0] sel);
        case (sel)
            2'd0: return cache_pkg::BYTE;
            2'd1: return cache_pkg::HALF;
            default: return cache_pkg::WORD;
        endcase
    endfunction

    function automatic logic [2:0] aligned_offset(input cache_pkg::req_width_e w,
                                                  input logic [2:0] bits);
        case (w)
            cache_pkg::BYTE: return bits;
            cache_pkg::HALF: return {bits[2:1], 1'b0};
            default: return {bits[2], 2'b00};
        endcase
    endfunction

    task automatic note_failure(input string line);
        errors++;
        $display("%s", line);
    endtask

    task automatic report_test(input string name);
        if (errors == test_mark) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - test_mark);
        end
        test_mark = errors;
    endtask

    // called at a falling edge, returns once the request is done
    task automatic issue_request(input cache_pkg::req_type_e rtype,
                                 input cache_pkg::req_width_e width,
                                 input logic [15:0] addr, input logic [31:0] data);
        int nbytes;
        int resp_mark;
        int writes_mark;
        nbytes = (width == cache_pkg::BYTE) ? 1 : (width == cache_pkg::HALF) ? 2 : 4;
        if (rtype == cache_pkg::WRITE) begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[addr + 16'(i)] = data[8*i +: 8];  // little endian
            end
        end
        exp_word = shadow_word(addr);
        exp_block = shadow_block(addr);
        reads_at_issue = total_reads;
        resp_mark = resp_count;
        writes_mark = total_writes;
        req.rtype = rtype;
        req.width = width;
        req.addr = addr;
        req.wr_data = data;
        req_valid = 1'b1;
        req_fresh = 1'b1;
        @(negedge clk);
        req_fresh = 1'b0;
        while (resp_count == resp_mark) begin
            @(negedge clk);
        end
        req_valid = 1'b0;
        while (rtype == cache_pkg::WRITE && total_writes == writes_mark) begin
            @(negedge clk);  // write-through accepted
        end
    endtask

    always @(posedge clk) begin
        if (resp_valid) resp_count <= resp_count + 1;
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req.rtype == cache_pkg::READ) total_reads <= total_reads + 1;
            else total_writes <= total_writes + 1;
        end
    end

    always @(negedge clk) begin
        stall_rng = xorshift32(stall_rng);
        stall = stall_on && stall_rng[0];  // about half the cycles
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (init)
        (resp_valid && req.rtype == cache_pkg::READ) |-> resp_data == exp_word)
        else note_failure($sformatf("FAIL resp_data got %h expected %h",
                                    $sampled(resp_data), $sampled(exp_word)));

    assert property (@(posedge clk) disable iff (init)
        mem_req_valid |-> mem_req.block_addr == {req.addr.tag, req.addr.index})
        else note_failure($sformatf("FAIL mem_req.block_addr got %h expected %h",
                                    $sampled(mem_req.block_addr),
                                    $sampled({req.addr.tag, req.addr.index})));

    assert property (@(posedge clk) disable iff (init)
        (mem_req_valid && mem_req.rtype == cache_pkg::WRITE) |-> mem_req.data == exp_block)
        else note_failure($sformatf("FAIL mem_req.data got %h expected %h",
                                    $sampled(mem_req.data), $sampled(exp_block)));

    assert property (@(posedge clk) disable iff (init)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else note_failure($sformatf("memory request not held while stalled, mem_req now %h",
                                    $sampled(mem_req)));

    // read hit answers in the cycle after the request is sampled
    assert property (@(posedge clk) disable iff (init) (expect_hit && req_fresh) |=> resp_valid)
        else note_failure("read hit did not respond in the next cycle");

    assert property (@(posedge clk) disable iff (init) expect_hit |-> !mem_req_valid)
        else note_failure("read hit issued a memory request");

    assert property (@(posedge clk) disable iff (init)
        (expect_miss && resp_valid) |-> total_reads == reads_at_issue + 1)
        else note_failure($sformatf("miss at %h did not refill exactly once", $sampled(req.addr)));

    assert property (@(posedge clk) disable iff (init) check_refetch |-> total_reads > reads_mark)
        else note_failure("rereading evicted tags issued no memory read");

    assert property (@(posedge clk) disable iff (init) resp_valid |-> req_valid)
        else note_failure("response without a pending request");

    assert property (@(posedge clk) (init || $past(init)) |-> (!resp_valid && !mem_req_valid))
        else note_failure("resp_valid or mem_req_valid high during or just after reset");

    initial begin : stimulus
        logic [15:0] addrs [4];
        logic [15:0] set_addr [3];
        logic [15:0] a;
        cache_pkg::req_width_e wsel;
        init = 1'b1;
        req_valid = 1'b0;
        req = '0;
        stall = 1'b0;
        stall_on = 1'b0;
        req_fresh = 1'b0;
        expect_hit = 1'b0;
        expect_miss = 1'b0;
        check_refetch = 1'b0;
        exp_word = '0;
        exp_block = '0;
        rng = 32'hd0a65aef;
        stall_rng = 32'hd0a65aef;
        for (int i = 0; i < 65536; i++) begin
            shadow[i[15:0]] = start_byte(i[15:0]);
        end
        repeat (16) @(negedge clk);
        init = 1'b0;
        @(negedge clk);

        expect_miss = 1'b1;
        for (int i = 0; i < 4; i++) begin
            rng = xorshift32(rng);
            addrs[i] = {rng[8:0], 4'(i), rng[14:12]};  // one cold set each
            issue_request(cache_pkg::READ, cache_pkg::WORD, addrs[i], '0);
        end
        expect_miss = 1'b0;
        report_test("cold read");

        expect_hit = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue_request(cache_pkg::READ, cache_pkg::WORD, addrs[i], '0);
        end
        expect_hit = 1'b0;
        report_test("read hit");

        for (int k = 0; k < 3; k++) begin
            wsel = pick_width(k[1:0]);
            rng = xorshift32(rng);
            a = {addrs[k][15:3], aligned_offset(wsel, rng[2:0])};
            issue_request(cache_pkg::WRITE, wsel, a, rng);
            issue_request(cache_pkg::READ, cache_pkg::WORD, a, '0);
            rng = xorshift32(rng);
            a = {rng[31:23], 4'(8 + k), aligned_offset(wsel, rng[2:0])};
            expect_miss = 1'b1;
            issue_request(cache_pkg::WRITE, wsel, a, rng);
            expect_miss = 1'b0;
            issue_request(cache_pkg::READ, cache_pkg::WORD, a, '0);
        end
        report_test("stores");

        rng = xorshift32(rng);
        expect_miss = 1'b1;
        for (int i = 0; i < 3; i++) begin
            set_addr[i] = {rng[8:0] ^ 9'(i), 4'd12, rng[11:9]};  // three tags, one set
            issue_request(cache_pkg::READ, cache_pkg::WORD, set_addr[i], '0);
        end
        expect_miss = 1'b0;
        reads_mark = total_reads;
        issue_request(cache_pkg::READ, cache_pkg::WORD, set_addr[0], '0);
        issue_request(cache_pkg::READ, cache_pkg::WORD, set_addr[1], '0);
        check_refetch = 1'b1;
        @(negedge clk);
        check_refetch = 1'b0;
        report_test("replacement");

        stall_on = 1'b1;
        for (int i = 0; i < 24; i++) begin
            rng = xorshift32(rng);
            wsel = pick_width(rng[1:0]);
            a = {5'h0, rng[19:16], rng[7:4], aligned_offset(wsel, rng[10:8])};
            if (rng[31]) begin
                rng = xorshift32(rng);
                issue_request(cache_pkg::WRITE, wsel, a, rng);
            end else begin
                issue_request(cache_pkg::READ, cache_pkg::WORD, a, '0);
            end
        end
        stall_on = 1'b0;
        report_test("back-pressure");

        issue_request(cache_pkg::READ, cache_pkg::WORD, addrs[1], '0);  // cached before the reset
        init = 1'b1;
        repeat (16) @(negedge clk);
        init = 1'b0;
        @(negedge clk);
        expect_miss = 1'b1;
        issue_request(cache_pkg::READ, cache_pkg::WORD, addrs[1], '0);
        expect_miss = 1'b0;
        report_test("reset");

        $display("6 tests, %0d failed, %0d check errors", tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* test/main_mem_model.sv */
`timescale 1ns/1ps

module main_mem_model (
    input  logic                              clk,
    input  logic                              init,
    input  logic                              stall,
    input  logic                              mem_req_valid,
    input  cache_pkg::mem_req_t               mem_req,
    output logic                              mem_req_ready,
    output logic                              mem_resp_valid,
    output logic [cache_pkg::BLOCK_WIDTH-1:0] mem_resp_data
);
    logic [cache_pkg::BLOCK_WIDTH-1:0]      blocks [2**cache_pkg::BLOCK_ADDR_WIDTH];
    logic [cache_pkg::BLOCK_ADDR_WIDTH-1:0] baddr;
    logic                                   busy;   // one request outstanding
    logic [1:0]                             delay;

    // low address byte scrambled, upper byte folded in
    function automatic logic [7:0] start_byte(input logic [15:0] a);
        return (a[7:0] * 8'h3b + 8'h11) ^ a[15:8];
    endfunction

    initial begin
        for (int blk = 0; blk < 2**cache_pkg::BLOCK_ADDR_WIDTH; blk++) begin
            for (int b = 0; b < cache_pkg::BLOCK_BYTES; b++) begin
                blocks[blk[12:0]][8*b +: 8] <= start_byte({blk[12:0], b[2:0]});
            end
        end
    end

    assign mem_req_ready = !stall;

    always @(posedge clk or posedge init) begin
        if (init) begin
            busy           <= 1'b0;
            delay          <= '0;
            mem_resp_valid <= 1'b0;
        end else begin
            mem_resp_valid <= 1'b0;
            if (busy) begin
                if (delay == '0) begin
                    busy           <= 1'b0;
                    mem_resp_valid <= 1'b1;
                    mem_resp_data  <= blocks[baddr];  // ignored for writes
                end else begin
                    delay <= delay - 2'd1;
                end
            end else if (mem_req_valid && mem_req_ready) begin
                busy  <= 1'b1;
                delay <= 2'd2;
                baddr <= mem_req.block_addr;
                if (mem_req.rtype == cache_pkg::WRITE) begin
                    blocks[mem_req.block_addr] <= mem_req.data;
                end
            end
        end
    end

endmodule
